//--- source/exec_pkg.sv
package exec_pkg;

    // datapath width fixed by the isa
    localparam int XLEN = 64;
    // word-mode operations only look at the low half
    localparam int XLEN_W = 32;

    // integer register file geometry
    localparam int REG_COUNT = 32;
    localparam int REG_ADDR_W = $clog2(REG_COUNT);

    typedef logic [XLEN-1:0] xdata_t;
    typedef logic [REG_ADDR_W-1:0] xaddr_t;

    // arithmetic lane opcodes
    // encoding 3 is never issued
    typedef enum logic [1:0] {
        ARITH_OP_ADD = 2'd0,
        ARITH_OP_SLT = 2'd1,
        ARITH_OP_CMP = 2'd2
    } arith_op_e;

    // logic lane opcodes
    typedef enum logic [1:0] {
        LOGIC_OP_AND = 2'd0,
        LOGIC_OP_OR  = 2'd1,
        LOGIC_OP_XOR = 2'd2,
        LOGIC_OP_SLA = 2'd3
    } logic_op_e;

    typedef struct packed {
        arith_op_e opsel;
        // negate op2 before the add, ADD only
        logic      sub;
        // unsigned compare for SLT, CMP and branch
        logic      is_unsigned;
        // 1 selects min, 0 selects max
        logic      cmp_min;
        // 1 compares equality, 0 compares less-than
        logic      br_equal;
        // flips the branch outcome (eq->ne, lt->ge)
        logic      br_invert;
        // 32-bit add, result sign extended
        logic      word;
    } arith_ctrl_t;

    typedef struct packed {
        logic_op_e  opsel;
        // use ~op2 for andn/orn/xnor
        logic       invert;
        // shift amount of op1 for scaled index add
        logic [1:0] sll;
    } logic_ctrl_t;

    // one issue slot per lane
    typedef struct packed {
        logic        valid;
        xaddr_t      rs1;
        xaddr_t      rs2;
        xaddr_t      rd;
        arith_ctrl_t ctrl;
    } arith_issue_t;

    typedef struct packed {
        logic        valid;
        xaddr_t      rs1;
        xaddr_t      rs2;
        xaddr_t      rd;
        logic_ctrl_t ctrl;
    } logic_issue_t;

    // lane result, also a register file write port
    typedef struct packed {
        logic   valid;
        xaddr_t rd;
        xdata_t data;
    } wb_t;

endpackage

//--- source/xrf.sv
module xrf (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // four synchronous read ports
    input  exec_pkg::xaddr_t i_rs1_addr,
    input  exec_pkg::xaddr_t i_rs2_addr,
    input  exec_pkg::xaddr_t i_rs3_addr,
    input  exec_pkg::xaddr_t i_rs4_addr,
    output exec_pkg::xdata_t o_rs1_rdata,
    output exec_pkg::xdata_t o_rs2_rdata,
    output exec_pkg::xdata_t o_rs3_rdata,
    output exec_pkg::xdata_t o_rs4_rdata,
    // write ports, port 1 has priority
    input  exec_pkg::wb_t    i_wb1,
    input  exec_pkg::wb_t    i_wb2
);
    import exec_pkg::*;

    // storage, entry 0 is never written
    xdata_t regs [REG_COUNT];

    // read ports as arrays so all four share one bypass path
    xaddr_t rs_addr [4];
    xdata_t rs_next [4];
    xdata_t rs_rdata [4];

    // qualified write enables, x0 writes dropped here
    logic wr1_en;
    logic wr2_en;

    assign wr1_en = i_wb1.valid && (i_wb1.rd != '0);
    assign wr2_en = i_wb2.valid && (i_wb2.rd != '0);

    assign rs_addr[0] = i_rs1_addr;
    assign rs_addr[1] = i_rs2_addr;
    assign rs_addr[2] = i_rs3_addr;
    assign rs_addr[3] = i_rs4_addr;

    // bypass a write landing on the same edge as the read
    // port 1 checked first to match the file update order below
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (wr1_en && (i_wb1.rd == rs_addr[p])) begin
                rs_next[p] = i_wb1.data;
            end else if (wr2_en && (i_wb2.rd == rs_addr[p])) begin
                rs_next[p] = i_wb2.data;
            end else begin
                rs_next[p] = regs[rs_addr[p]];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // whole file cleared, x0 included
            for (int r = 0; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
            for (int p = 0; p < 4; p++) begin
                rs_rdata[p] <= '0;
            end
        end else begin
            // read data out one cycle after the address
            for (int p = 0; p < 4; p++) begin
                rs_rdata[p] <= rs_next[p];
            end
            if (wr2_en) begin
                regs[i_wb2.rd] <= i_wb2.data;
            end
            // later nonblocking write wins, so port 1 takes a shared rd
            if (wr1_en) begin
                regs[i_wb1.rd] <= i_wb1.data;
            end
        end
    end

    assign o_rs1_rdata = rs_rdata[0];
    assign o_rs2_rdata = rs_rdata[1];
    assign o_rs3_rdata = rs_rdata[2];
    assign o_rs4_rdata = rs_rdata[3];

    // x0 holds zero across every write either lane sends back
    a_x0_zero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        regs[0] == '0
    );

endmodule

//--- source/xarith.sv
module xarith (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // issue strobe with rd and control, operands follow a cycle later
    input  exec_pkg::arith_issue_t i_issue,
    input  exec_pkg::xdata_t       i_op1,
    input  exec_pkg::xdata_t       i_op2,
    output exec_pkg::wb_t          o_wb,
    // taken flag, valid alongside o_wb.valid
    output logic                   o_branch
);
    import exec_pkg::*;

    // stage 1, captured at issue
    logic          r_valid;
    xaddr_t        r_rd;
    arith_ctrl_t   r_ctrl;

    // stage 2 datapath
    xdata_t        add_op2;
    xdata_t        sum;
    xdata_t        add_result;
    logic [XLEN:0] cmp_op1;
    logic [XLEN:0] cmp_op2;
    logic [XLEN:0] diff;
    logic          lt;
    logic          eq;
    xdata_t        cmp_result;
    logic          branch;
    xdata_t        result;

    // stage 2 output registers
    logic          wb_valid;
    xaddr_t        wb_rd;
    xdata_t        wb_data;
    logic          wb_branch;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
            r_rd    <= '0;
            r_ctrl  <= '0;
        end else begin
            r_valid <= i_issue.valid;
            r_rd    <= i_issue.rd;
            r_ctrl  <= i_issue.ctrl;
        end
    end

    // add/sub, two's complement negate via invert plus carry in
    assign add_op2 = r_ctrl.sub ? ~i_op2 : i_op2;
    assign sum = i_op1 + add_op2 + xdata_t'(r_ctrl.sub);
    // word mode keeps the low half and sign extends it
    assign add_result = r_ctrl.word ?
        {{(XLEN - XLEN_W){sum[XLEN_W-1]}}, sum[XLEN_W-1:0]} : sum;

    // compare path always subtracts, independent of the sub bit
    // one extra bit: sign extend for signed, zero extend for unsigned
    assign cmp_op1 = {i_op1[XLEN-1] & ~r_ctrl.is_unsigned, i_op1};
    assign cmp_op2 = {i_op2[XLEN-1] & ~r_ctrl.is_unsigned, i_op2};
    assign diff = cmp_op1 - cmp_op2;
    // sign of the 65-bit difference is op1 < op2
    assign lt = diff[XLEN];
    assign eq = (i_op1 == i_op2);

    // min keeps op1 when lt, max keeps op1 when not lt
    assign cmp_result = (lt == r_ctrl.cmp_min) ? i_op1 : i_op2;

    assign branch = (r_ctrl.br_equal ? eq : lt) ^ r_ctrl.br_invert;

    always_comb begin
        case (r_ctrl.opsel)
            ARITH_OP_ADD: result = add_result;
            ARITH_OP_SLT: result = xdata_t'(lt);
            ARITH_OP_CMP: result = cmp_result;
            default:      result = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_valid  <= 1'b0;
            wb_rd     <= '0;
            wb_branch <= 1'b0;
        end else begin
            wb_valid  <= r_valid;
            wb_rd     <= r_rd;
            wb_branch <= branch;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_data <= result;
    end

    assign o_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};
    assign o_branch = wb_branch;

    // an instruction in stage 2 never carries the unused opcode
    a_opsel_legal: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        r_valid |-> (r_ctrl.opsel inside {ARITH_OP_ADD, ARITH_OP_SLT, ARITH_OP_CMP})
    );

endmodule

//--- source/xlogic.sv
module xlogic (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // issue strobe with rd and control, operands follow a cycle later
    input  exec_pkg::logic_issue_t i_issue,
    input  exec_pkg::xdata_t       i_op1,
    input  exec_pkg::xdata_t       i_op2,
    output exec_pkg::wb_t          o_wb
);
    import exec_pkg::*;

    // stage 1, captured at issue
    logic        r_valid;
    xaddr_t      r_rd;
    logic_ctrl_t r_ctrl;

    // stage 2 datapath
    xdata_t      op2;
    xdata_t      sla_result;
    xdata_t      result;

    // stage 2 output registers
    logic        wb_valid;
    xaddr_t      wb_rd;
    xdata_t      wb_data;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
            r_rd    <= '0;
            r_ctrl  <= '0;
        end else begin
            r_valid <= i_issue.valid;
            r_rd    <= i_issue.rd;
            r_ctrl  <= i_issue.ctrl;
        end
    end

    // optional op2 inversion gives andn, orn and xnor
    assign op2 = r_ctrl.invert ? ~i_op2 : i_op2;

    // address generation: base scaled by 1/2/4/8 plus offset
    assign sla_result = (i_op1 << r_ctrl.sll) + i_op2;

    always_comb begin
        case (r_ctrl.opsel)
            LOGIC_OP_AND: result = i_op1 & op2;
            LOGIC_OP_OR:  result = i_op1 | op2;
            LOGIC_OP_XOR: result = i_op1 ^ op2;
            default:      result = sla_result;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
        end else begin
            wb_valid <= r_valid;
            wb_rd    <= r_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_data <= result;
    end

    assign o_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

    // write port control seen by the register file is never unknown
    a_wb_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown({o_wb.valid, o_wb.rd})
    );

endmodule

//--- source/exec_cluster.sv
module exec_cluster (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // one issue slot per lane per cycle, no back-pressure
    input  exec_pkg::arith_issue_t i_arith,
    input  exec_pkg::logic_issue_t i_logic,
    // lane results, two cycles after issue
    output exec_pkg::wb_t          o_arith_wb,
    output exec_pkg::wb_t          o_logic_wb,
    output logic                   o_branch
);
    import exec_pkg::*;

    // register file read data, one cycle after issue
    xdata_t arith_op1;
    xdata_t arith_op2;
    xdata_t logic_op1;
    xdata_t logic_op2;

    // lane writebacks, also fed back into the file
    wb_t    arith_wb;
    wb_t    logic_wb;

    // ports 1/2 serve the arithmetic lane, 3/4 the logic lane
    // arithmetic writes on port 1 so it wins a shared rd
    xrf u_rf (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rs1_addr  (i_arith.rs1),
        .i_rs2_addr  (i_arith.rs2),
        .i_rs3_addr  (i_logic.rs1),
        .i_rs4_addr  (i_logic.rs2),
        .o_rs1_rdata (arith_op1),
        .o_rs2_rdata (arith_op2),
        .o_rs3_rdata (logic_op1),
        .o_rs4_rdata (logic_op2),
        .i_wb1       (arith_wb),
        .i_wb2       (logic_wb)
    );

    // add/sub, slt, min/max and branch
    xarith u_arith (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_issue  (i_arith),
        .i_op1    (arith_op1),
        .i_op2    (arith_op2),
        .o_wb     (arith_wb),
        .o_branch (o_branch)
    );

    // bitwise ops and scaled index add
    xlogic u_logic (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_issue (i_logic),
        .i_op1   (logic_op1),
        .i_op2   (logic_op2),
        .o_wb    (logic_wb)
    );

    // results leave the cluster the same cycle they reach the write ports
    assign o_arith_wb = arith_wb;
    assign o_logic_wb = logic_wb;

endmodule

//--- verification/clk_gen.sv
module clk_gen (
    output logic o_clk
);

    // free running clock with a period of 4
    initial begin
        o_clk = 1'b0;
    end

    always begin
        #2 o_clk = ~o_clk;
    end

endmodule

//--- verification/tb_exec_cluster.sv
module tb_exec_cluster;
    import exec_pkg::*;

    // 10 reset cycles, 5 tests of at most 400 cycles, 50 to drain
    localparam int CYCLE_LIMIT = 10 + 5 * 400 + 50;

    logic         clk;
    logic         rst_n;
    arith_issue_t arith_in;
    logic_issue_t logic_in;
    wb_t          arith_wb;
    wb_t          logic_wb;
    logic         branch;

    // reference register file and the in-flight results of each lane
    xdata_t       model_regs [REG_COUNT];
    wb_t          arith_q [$];
    wb_t          logic_q [$];
    logic         branch_q [$];
    // what the DUT outputs should show in the current cycle
    wb_t          exp_arith;
    wb_t          exp_logic;
    logic         exp_branch;
    // issue words the DUT samples on the coming edge
    arith_issue_t cur_arith;
    logic_issue_t cur_logic;

    int           cycles = 0;
    int           err_count = 0;
    int           tests_passed = 0;
    int           tests_failed = 0;
    int           rd_hi = 31;
    logic         bias = 1'b0;
    int unsigned  seed_ret;

    clk_gen u_clk (.o_clk(clk));

    exec_cluster dut0 (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_arith    (arith_in),
        .i_logic    (logic_in),
        .o_arith_wb (arith_wb),
        .o_logic_wb (logic_wb),
        .o_branch   (branch)
    );

    function automatic logic less_than(logic uns, xdata_t a, xdata_t b);
        if (uns) begin
            return a < b;
        end
        return $signed(a) < $signed(b);
    endfunction

    function automatic xdata_t arith_result(arith_ctrl_t c, xdata_t a, xdata_t b);
        xdata_t s;
        logic   lt;
        lt = less_than(c.is_unsigned, a, b);
        case (c.opsel)
            ARITH_OP_ADD: begin
                s = c.sub ? a - b : a + b;
                // word mode keeps the low 32 bits sign extended
                if (c.word) begin
                    s = {{32{s[31]}}, s[31:0]};
                end
            end
            ARITH_OP_SLT: s = xdata_t'(lt);
            default:      s = c.cmp_min ? (lt ? a : b) : (lt ? b : a);
        endcase
        return s;
    endfunction

    // equality or less-than, optionally flipped
    function automatic logic branch_result(arith_ctrl_t c, xdata_t a, xdata_t b);
        logic cond;
        cond = c.br_equal ? (a == b) : less_than(c.is_unsigned, a, b);
        return cond != c.br_invert;
    endfunction

    function automatic xdata_t logic_result(logic_ctrl_t c, xdata_t a, xdata_t b);
        xdata_t nb;
        xdata_t s;
        nb = c.invert ? ~b : b;
        case (c.opsel)
            LOGIC_OP_AND: s = a & nb;
            LOGIC_OP_OR:  s = a | nb;
            LOGIC_OP_XOR: s = a ^ nb;
            // base times 1, 2, 4 or 8 plus offset
            default:      s = a * (xdata_t'(1) << c.sll) + b;
        endcase
        return s;
    endfunction

    function automatic arith_issue_t make_add(int rs1, int rs2, int rd);
        arith_issue_t a;
        a = '0;
        a.valid = 1'b1;
        a.rs1 = xaddr_t'(rs1);
        a.rs2 = xaddr_t'(rs2);
        a.rd = xaddr_t'(rd);
        a.ctrl.opsel = ARITH_OP_ADD;
        return a;
    endfunction

    function automatic logic_issue_t make_logic(logic_op_e op, logic inv, int sll,
                                                int rs1, int rs2, int rd);
        logic_issue_t l;
        l = '0;
        l.valid = 1'b1;
        l.rs1 = xaddr_t'(rs1);
        l.rs2 = xaddr_t'(rs2);
        l.rd = xaddr_t'(rd);
        l.ctrl.opsel = op;
        l.ctrl.invert = inv;
        l.ctrl.sll = 2'(sll);
        return l;
    endfunction

    // biased picks favour x0 and the boundary values kept in x29..x31
    function automatic xaddr_t pick_src();
        int r;
        if (bias && $urandom_range(3) == 0) begin
            r = $urandom_range(3);
            return (r == 0) ? xaddr_t'(0) : xaddr_t'(28 + r);
        end
        return xaddr_t'($urandom_range(31));
    endfunction

    function automatic arith_issue_t rand_arith(int op_lo, int op_hi);
        arith_issue_t a;
        a.valid = $urandom_range(7) != 0;
        a.rs1 = pick_src();
        // equal operands now and then for eq, min and max corners
        a.rs2 = (bias && $urandom_range(3) == 0) ? a.rs1 : pick_src();
        a.rd = xaddr_t'($urandom_range(rd_hi, 1));
        a.ctrl = arith_ctrl_t'(8'($urandom));
        a.ctrl.opsel = arith_op_e'(2'($urandom_range(op_hi, op_lo)));
        return a;
    endfunction

    function automatic logic_issue_t rand_logic();
        logic_issue_t l;
        l.valid = $urandom_range(7) != 0;
        l.rs1 = pick_src();
        l.rs2 = pick_src();
        l.rd = xaddr_t'($urandom_range(rd_hi, 1));
        l.ctrl = logic_ctrl_t'(5'($urandom));
        return l;
    endfunction

    // one DUT edge of the model
    task automatic model_edge(arith_issue_t a, logic_issue_t l);
        wb_t na;
        wb_t nl;
        // commit what was visible before the edge, arithmetic last so it wins
        if (exp_logic.valid && exp_logic.rd != '0) begin
            model_regs[exp_logic.rd] = exp_logic.data;
        end
        if (exp_arith.valid && exp_arith.rd != '0) begin
            model_regs[exp_arith.rd] = exp_arith.data;
        end
        // operands read after the commit, which is the same-edge bypass
        na.valid = a.valid;
        na.rd = a.rd;
        na.data = arith_result(a.ctrl, model_regs[a.rs1], model_regs[a.rs2]);
        nl.valid = l.valid;
        nl.rd = l.rd;
        nl.data = logic_result(l.ctrl, model_regs[l.rs1], model_regs[l.rs2]);
        arith_q.push_back(na);
        logic_q.push_back(nl);
        branch_q.push_back(branch_result(a.ctrl, model_regs[a.rs1], model_regs[a.rs2]));
        // the entry sampled on the previous edge becomes visible now
        exp_arith = arith_q.pop_front();
        exp_logic = logic_q.pop_front();
        exp_branch = branch_q.pop_front();
    endtask

    task automatic check_field(string name, xdata_t exp, xdata_t got);
        assert (got === exp) else begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic check_outputs();
        check_field("o_arith_wb.valid", 64'(exp_arith.valid), 64'(arith_wb.valid));
        check_field("o_logic_wb.valid", 64'(exp_logic.valid), 64'(logic_wb.valid));
        if (exp_arith.valid) begin
            check_field("o_arith_wb.rd", 64'(exp_arith.rd), 64'(arith_wb.rd));
            check_field("o_arith_wb.data", exp_arith.data, arith_wb.data);
            check_field("o_branch", 64'(exp_branch), 64'(branch));
        end
        if (exp_logic.valid) begin
            check_field("o_logic_wb.rd", 64'(exp_logic.rd), 64'(logic_wb.rd));
            check_field("o_logic_wb.data", exp_logic.data, logic_wb.data);
        end
    endtask

    // drive on the rising edge, compare on the falling edge
    task automatic step(arith_issue_t na, logic_issue_t nl);
        @(posedge clk);
        model_edge(cur_arith, cur_logic);
        arith_in <= na;
        logic_in <= nl;
        cur_arith = na;
        cur_logic = nl;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle(int n);
        repeat (n) begin
            step('0, '0);
        end
    endtask

    task automatic run_random(int op_lo, int op_hi, int count);
        repeat (count) begin
            step(rand_arith(op_lo, op_hi), rand_logic());
        end
        idle(4);
    endtask

    // x29 = -1, x31 = most negative, x30 = most positive
    task automatic build_boundaries();
        step('0, make_logic(LOGIC_OP_XOR, 1'b1, 0, 0, 0, 31));
        step('0, make_logic(LOGIC_OP_XOR, 1'b1, 0, 0, 0, 29));
        idle(2);
        // 21 shifts by 3 move the all-ones value up to bit 63 alone
        repeat (21) begin
            step('0, make_logic(LOGIC_OP_SLA, 1'b0, 3, 31, 0, 31));
            idle(2);
        end
        step(make_add(31, 29, 30), '0);
        idle(2);
    endtask

    // write, wait d-1 cycles, then read back through both lanes
    task automatic dep_probe(arith_issue_t wa, logic_issue_t wl, int probe);
        for (int d = 1; d <= 4; d++) begin
            step(make_add(0, 0, probe), '0);
            idle(3);
            step(wa, wl);
            idle(d - 1);
            step(make_add(probe, 0, 6), make_logic(LOGIC_OP_OR, 1'b0, 0, probe, 0, 11));
            idle(3);
        end
    endtask

    task automatic finish_test(int num, string name, int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
        end
    endtask

    // hard stop in case a test never returns
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, tests did not finish", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int errs;
        seed_ret = $urandom(22);
        rst_n = 1'b0;
        arith_in = '0;
        logic_in = '0;
        cur_arith = '0;
        cur_logic = '0;
        exp_arith = '0;
        exp_logic = '0;
        exp_branch = 1'b0;
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        // pipeline starts with one empty slot
        arith_q.push_back('0);
        logic_q.push_back('0);
        branch_q.push_back(1'b0);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        errs = err_count;
        @(negedge clk);
        check_field("o_arith_wb.valid", 64'd0, 64'(arith_wb.valid));
        check_field("o_logic_wb.valid", 64'd0, 64'(logic_wb.valid));
        check_field("o_branch", 64'd0, 64'(branch));
        for (int r = 0; r < REG_COUNT; r++) begin
            step(make_add(r, 0, 0), make_logic(LOGIC_OP_XOR, 1'b0, 0, r, 0, 0));
        end
        idle(4);
        finish_test(1, "reset state", errs);

        errs = err_count;
        run_random(0, 0, 300);
        finish_test(2, "add and subtract", errs);

        errs = err_count;
        build_boundaries();
        bias = 1'b1;
        rd_hi = 28;
        run_random(1, 2, 300);
        bias = 1'b0;
        rd_hi = 31;
        finish_test(3, "comparisons and branches", errs);

        errs = err_count;
        run_random(0, 2, 300);
        finish_test(4, "logic lane", errs);

        errs = err_count;
        step('0, make_logic(LOGIC_OP_XOR, 1'b1, 0, 0, 0, 8));
        idle(3);
        dep_probe('0, make_logic(LOGIC_OP_XOR, 1'b1, 0, 0, 0, 5), 5);
        dep_probe(make_add(8, 8, 5), '0, 5);
        // both lanes on x7, the arithmetic value must survive
        dep_probe(make_add(8, 8, 7), make_logic(LOGIC_OP_AND, 1'b0, 0, 8, 8, 7), 7);
        dep_probe(make_add(8, 8, 0), make_logic(LOGIC_OP_XOR, 1'b1, 0, 0, 0, 0), 0);
        finish_test(5, "writeback and dependencies", errs);

        $display("tests ok %0d, tests failing %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/exec_pkg.sv
source/xrf.sv
source/xarith.sv
source/xlogic.sv
source/exec_cluster.sv
verification/clk_gen.sv
verification/tb_exec_cluster.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and pass only on the testbench pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_exec_cluster -f verilog.f -o sim_exec \
    && ./obj_dir/sim_exec | tee /dev/stderr | grep -q "Verification passed" \
    || exit 1
